//--- src/cps_mix_pkg.sv
// ----------------------------------------------------------
// Shared types and constants for the CPS colour mixer
// Colour nibble 0xF marks a transparent pixel on every layer
// Register map is word aligned on an 8-bit APB address
// ----------------------------------------------------------
package cps_mix_pkg;

    // Pixel formats
    typedef logic [10:0] scr_pxl_t;   // group, palette, colour
    typedef logic [8:0]  spr_pxl_t;   // palette, colour
    typedef logic [11:0] pal_idx_t;   // layer code, pixel
    typedef logic [3:0]  colour_t;
    typedef logic [1:0]  group_t;

    // Configuration field widths
    typedef logic [15:0] lyr_ctrl_t;
    typedef logic [7:0]  lyr_mask_t;
    typedef logic [15:0] prio_mask_t;
    typedef logic [3:0]  gfx_en_t;

    localparam colour_t COLOUR_TRANSP = 4'hF;

    // Layer code, top bits of the palette index
    typedef enum logic [2:0] {
        LYR_OBJ  = 3'd0,
        LYR_SCR1 = 3'd1,
        LYR_SCR2 = 3'd2,
        LYR_SCR3 = 3'd3,
        LYR_STAR = 3'd4
    } layer_code_e;

    // One layer waiting to be resolved
    typedef struct packed {
        group_t      group;
        layer_code_e code;
        spr_pxl_t    pxl;
    } staged_pxl_t;

    typedef struct packed {
        scr_pxl_t scr1;
        scr_pxl_t scr2;
        scr_pxl_t scr3;
        spr_pxl_t star0;
        spr_pxl_t star1;
        spr_pxl_t obj;
    } layer_pxls_t;

    typedef struct packed {
        lyr_ctrl_t        layer_ctrl;
        lyr_mask_t  [4:0] mask;   // scr1, scr2, scr3, star0, star1
        prio_mask_t [3:0] prio;   // one per scroll group
        gfx_en_t          gfx_en;
    } mix_cfg_t;

    // Queue filler, transparent with an unused layer code
    localparam staged_pxl_t BLANK_PXL = staged_pxl_t'(14'h3FFF);

    // APB register map
    localparam int APB_AW = 8;
    typedef logic [APB_AW-1:0] apb_addr_t;

    localparam apb_addr_t REG_LAYER_CTRL = 8'h00;
    localparam apb_addr_t REG_MASK0      = 8'h04;
    localparam apb_addr_t REG_MASK1      = 8'h08;
    localparam apb_addr_t REG_MASK2      = 8'h0C;
    localparam apb_addr_t REG_MASK3      = 8'h10;
    localparam apb_addr_t REG_MASK4      = 8'h14;
    localparam apb_addr_t REG_PRIO0      = 8'h18;
    localparam apb_addr_t REG_PRIO1      = 8'h1C;
    localparam apb_addr_t REG_PRIO2      = 8'h20;
    localparam apb_addr_t REG_PRIO3      = 8'h24;
    localparam apb_addr_t REG_GFX_EN     = 8'h28;

endpackage

//--- src/cps_mix_regs.sv
// ----------------------------------------------------------
// APB configuration registers of the colour mixer
// pready is tied high, every access takes two cycles
// Unmapped offsets raise pslverr, ignore writes, read as 0
// ----------------------------------------------------------
`timescale 1ns/1ps

module cps_mix_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cps_mix_pkg::APB_AW-1:0] paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output cps_mix_pkg::mix_cfg_t         cfg
);

    logic access;
    logic addr_hit;

    // Access phase of any transfer
    assign access = psel && penable;

    // Address decode and zero-extended read data
    always_comb begin
        addr_hit = 1'b1;
        prdata   = 32'h0;
        case (paddr)
            cps_mix_pkg::REG_LAYER_CTRL: prdata = {16'h0, cfg.layer_ctrl};
            cps_mix_pkg::REG_MASK0:      prdata = {24'h0, cfg.mask[0]};
            cps_mix_pkg::REG_MASK1:      prdata = {24'h0, cfg.mask[1]};
            cps_mix_pkg::REG_MASK2:      prdata = {24'h0, cfg.mask[2]};
            cps_mix_pkg::REG_MASK3:      prdata = {24'h0, cfg.mask[3]};
            cps_mix_pkg::REG_MASK4:      prdata = {24'h0, cfg.mask[4]};
            cps_mix_pkg::REG_PRIO0:      prdata = {16'h0, cfg.prio[0]};
            cps_mix_pkg::REG_PRIO1:      prdata = {16'h0, cfg.prio[1]};
            cps_mix_pkg::REG_PRIO2:      prdata = {16'h0, cfg.prio[2]};
            cps_mix_pkg::REG_PRIO3:      prdata = {16'h0, cfg.prio[3]};
            cps_mix_pkg::REG_GFX_EN:     prdata = {28'h0, cfg.gfx_en};
            default:                     addr_hit = 1'b0;
        endcase
    end

    // No wait states
    assign pready = 1'b1;

    // Error only in the access phase of a miss
    assign pslverr = access && !addr_hit;

    // Register writes, truncated to each field width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Order selects zero, all six enable bits set
            cfg.layer_ctrl <= 16'h003F;
            for (int i = 0; i < 5; i++) begin
                cfg.mask[i] <= 8'h3F;
            end
            for (int i = 0; i < 4; i++) begin
                cfg.prio[i] <= 16'h0;
            end
            cfg.gfx_en <= 4'hF;
        end else if (access && pwrite) begin
            case (paddr)
                cps_mix_pkg::REG_LAYER_CTRL: cfg.layer_ctrl <= pwdata[15:0];
                cps_mix_pkg::REG_MASK0:      cfg.mask[0]    <= pwdata[7:0];
                cps_mix_pkg::REG_MASK1:      cfg.mask[1]    <= pwdata[7:0];
                cps_mix_pkg::REG_MASK2:      cfg.mask[2]    <= pwdata[7:0];
                cps_mix_pkg::REG_MASK3:      cfg.mask[3]    <= pwdata[7:0];
                cps_mix_pkg::REG_MASK4:      cfg.mask[4]    <= pwdata[7:0];
                cps_mix_pkg::REG_PRIO0:      cfg.prio[0]    <= pwdata[15:0];
                cps_mix_pkg::REG_PRIO1:      cfg.prio[1]    <= pwdata[15:0];
                cps_mix_pkg::REG_PRIO2:      cfg.prio[2]    <= pwdata[15:0];
                cps_mix_pkg::REG_PRIO3:      cfg.prio[3]    <= pwdata[15:0];
                cps_mix_pkg::REG_GFX_EN:     cfg.gfx_en     <= pwdata[3:0];
                // Misses leave every register alone
                default: ;
            endcase
        end
    end

endmodule

//--- src/cps_layer_gate.sv
// ----------------------------------------------------------
// Layer enable gating, purely combinational
// Disabled layers keep palette bits, colour forced to 0xF
// Object layer depends on gfx_en bit 3 only
// ----------------------------------------------------------
`timescale 1ns/1ps

module cps_layer_gate (
    input  cps_mix_pkg::layer_pxls_t layers,
    input  cps_mix_pkg::mix_cfg_t    cfg,
    output cps_mix_pkg::layer_pxls_t gated
);

    // Mask hit per layer: scr1, scr2, scr3, star0, star1
    logic [4:0] mask_hit;

    // Force colour nibble transparent when disabled
    function automatic cps_mix_pkg::spr_pxl_t force_transp(
        input cps_mix_pkg::spr_pxl_t pxl,
        input logic                  en
    );
        cps_mix_pkg::spr_pxl_t res;
        res = pxl;
        if (!en) begin
            res[3:0] = cps_mix_pkg::COLOUR_TRANSP;
        end
        return res;
    endfunction

    // Any mask bit shared with the low six control bits
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            mask_hit[i] = |(cfg.mask[i][5:0] & cfg.layer_ctrl[5:0]);
        end
    end

    // Scroll layers also need their own gfx_en bit
    always_comb begin
        gated.scr1 = {layers.scr1[10:9],
                      force_transp(layers.scr1[8:0], mask_hit[0] && cfg.gfx_en[0])};
        gated.scr2 = {layers.scr2[10:9],
                      force_transp(layers.scr2[8:0], mask_hit[1] && cfg.gfx_en[1])};
        gated.scr3 = {layers.scr3[10:9],
                      force_transp(layers.scr3[8:0], mask_hit[2] && cfg.gfx_en[2])};
        // Star fields only follow their masks
        gated.star0 = force_transp(layers.star0, mask_hit[3]);
        gated.star1 = force_transp(layers.star1, mask_hit[4]);
        gated.obj   = force_transp(layers.obj, cfg.gfx_en[3]);
    end

endmodule

//--- src/cps_layer_mixer.sv
// ----------------------------------------------------------
// Serial layer resolution between pixel enables
// Needs at least 5 low clocks between pxl_cen pulses
// Result of enable k appears on pxl at enable k+2
// ----------------------------------------------------------
`timescale 1ns/1ps

module cps_layer_mixer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxl_cen,
    input  cps_mix_pkg::layer_pxls_t gated,
    input  cps_mix_pkg::mix_cfg_t    cfg,
    output cps_mix_pkg::pal_idx_t    pxl
);

    // Staged layers, captured at the first enable
    cps_mix_pkg::staged_pxl_t       stg_star0;
    cps_mix_pkg::staged_pxl_t       stg_star1;
    cps_mix_pkg::staged_pxl_t [3:0] stg_ord;

    // Candidates still to be considered, entry 0 next
    cps_mix_pkg::staged_pxl_t [4:0] queue;
    cps_mix_pkg::staged_pxl_t       cur;
    cps_mix_pkg::staged_pxl_t       cand;

    logic check_prio;
    logic has_prio;
    logic take;

    // Order select to staged layer
    function automatic cps_mix_pkg::staged_pxl_t sel_layer(
        input logic [1:0]               sel,
        input cps_mix_pkg::layer_pxls_t lyr
    );
        cps_mix_pkg::staged_pxl_t res;
        case (sel)
            2'd0: res = '{group: 2'b00, code: cps_mix_pkg::LYR_OBJ, pxl: lyr.obj};
            2'd1: res = '{group: lyr.scr1[10:9], code: cps_mix_pkg::LYR_SCR1,
                          pxl: lyr.scr1[8:0]};
            2'd2: res = '{group: lyr.scr2[10:9], code: cps_mix_pkg::LYR_SCR2,
                          pxl: lyr.scr2[8:0]};
            default: res = '{group: lyr.scr3[10:9], code: cps_mix_pkg::LYR_SCR3,
                             pxl: lyr.scr3[8:0]};
        endcase
        return res;
    endfunction

    // Capture stars and the four ordered layers
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            stg_star0 <= '{group: 2'b00, code: cps_mix_pkg::LYR_STAR, pxl: gated.star0};
            stg_star1 <= '{group: 2'b00, code: cps_mix_pkg::LYR_STAR, pxl: gated.star1};
            // Bits 7:6 first, bits 13:12 last
            for (int i = 0; i < 4; i++) begin
                stg_ord[i] <= sel_layer(cfg.layer_ctrl[6 + 2*i +: 2], gated);
            end
        end
    end

    assign cand = queue[0];

    // Group priority mask bit at the current colour
    assign has_prio = cfg.prio[cur.group][cur.pxl[3:0]];

    // Queue filler is never a candidate
    // Objects lose to a scroll pixel with its priority bit set
    always_comb begin
        take = (cand != cps_mix_pkg::BLANK_PXL) &&
               ((cur.pxl[3:0] == cps_mix_pkg::COLOUR_TRANSP) ||
                (!(cand.code == cps_mix_pkg::LYR_OBJ && has_prio && check_prio) &&
                 cand.pxl[3:0] != cps_mix_pkg::COLOUR_TRANSP));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl        <= '0;
            cur        <= '0;
            queue      <= {5{cps_mix_pkg::BLANK_PXL}};
            check_prio <= 1'b0;
        end else if (pxl_cen) begin
            // Previous result out, next pixel in
            pxl        <= {cur.code, cur.pxl};
            cur        <= stg_star1;
            queue      <= {stg_ord[3], stg_ord[2], stg_ord[1], stg_ord[0], stg_star0};
            check_prio <= 1'b0;
        end else begin
            // One candidate per clock
            queue <= {cps_mix_pkg::BLANK_PXL, queue[4:1]};
            if (take) begin
                cur        <= cand;
                check_prio <= cand.code != cps_mix_pkg::LYR_STAR;
            end else begin
                check_prio <= 1'b0;
            end
        end
    end

endmodule

//--- src/cps_video_mixer.sv
// ----------------------------------------------------------
// Colour mixer top: APB registers, layer gate, mixer
// pxl_cen comes from external video timing
// Pixel path has no handshake and never stalls
// ----------------------------------------------------------
`timescale 1ns/1ps

module cps_video_mixer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pxl_cen,
    // APB configuration port
    input  logic [cps_mix_pkg::APB_AW-1:0] paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    // Layer pixels in, palette index out
    input  cps_mix_pkg::layer_pxls_t       layers,
    output cps_mix_pkg::pal_idx_t          pxl
);

    cps_mix_pkg::mix_cfg_t    cfg;
    cps_mix_pkg::layer_pxls_t gated;

    cps_mix_regs cps_mix_regs_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg)
    );

    // Enables applied before staging
    cps_layer_gate cps_layer_gate_inst (
        .layers (layers),
        .cfg    (cfg),
        .gated  (gated)
    );

    cps_layer_mixer cps_layer_mixer_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .gated   (gated),
        .cfg     (cfg),
        .pxl     (pxl)
    );

endmodule

//--- verification/cps_mix_chk.sv
// ----------------------------------------------------------
// Bound checks on APB phases and pixel enable timing
// Expects at least 5 low clocks between pxl_cen pulses
// ----------------------------------------------------------
`timescale 1ns/1ps

module cps_mix_chk (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  pxl_cen,
    input logic                  psel,
    input logic                  penable,
    input cps_mix_pkg::pal_idx_t pxl
);

    // Five low clocks between two enables
    cen_gap: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen |-> !($past(pxl_cen, 1) || $past(pxl_cen, 2) || $past(pxl_cen, 3) ||
                      $past(pxl_cen, 4) || $past(pxl_cen, 5)))
        else $error("pxl_cen pulses closer than 6 clocks apart");

    // Output only moves on the edge of an enable
    pxl_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(pxl_cen) |-> $stable(pxl))
        else $error("pxl changed without a pixel enable");

    // Access phase needs a setup phase with psel
    apb_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel && $past(psel) && !$past(penable))
        else $error("penable raised without a setup phase");

    apb_sel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else $error("penable high while psel low");

endmodule

bind cps_video_mixer cps_mix_chk cps_mix_chk_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .pxl_cen (pxl_cen),
    .psel    (psel),
    .penable (penable),
    .pxl     (pxl)
);

//--- verification/tb_cps_video_mixer.sv
// ----------------------------------------------------------
// Testbench for the colour mixer top level
// pxl_cen pulses every 8 clocks, config written only when idle
// Each pixel is checked three enables after it is sampled
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_cps_video_mixer;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           pxl_cen;
    logic [cps_mix_pkg::APB_AW-1:0] paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [31:0]                    pwdata;
    logic [31:0]                    prdata;
    logic                           pready;
    logic                           pslverr;
    cps_mix_pkg::layer_pxls_t       layers;
    cps_mix_pkg::pal_idx_t          pxl;

    // Register model and the pixel now on the inputs
    cps_mix_pkg::mix_cfg_t model_cfg;
    cps_mix_pkg::pal_idx_t exp_pxl;
    logic                  exp_valid;
    logic [2:0]            v_pipe = 3'b000;
    cps_mix_pkg::pal_idx_t e_pipe [3];
    integer                seed = 32'h312b_d6b6;
    int                    err_cnt = 0;
    int                    chk_cnt = 0;

    cps_video_mixer cps_video_mixer_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .layers  (layers),
        .pxl     (pxl)
    );

    always #10 clk = ~clk;

    // One-clock enable every 8 clocks once reset is over
    initial begin
        pxl_cen = 1'b0;
        repeat (8) @(posedge clk);
        forever begin
            @(posedge clk);
            #1 pxl_cen = 1'b1;
            @(posedge clk);
            #1 pxl_cen = 1'b0;
            repeat (6) @(posedge clk);
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: no %s within 20 clocks", what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // Reference: gate the layers, then resolve star1, star0 and four ordered slots
    function automatic cps_mix_pkg::pal_idx_t ref_mix(
        input cps_mix_pkg::mix_cfg_t    c,
        input cps_mix_pkg::layer_pxls_t l
    );
        logic [4:0] on;
        logic [8:0] lyr_px [4];
        logic [1:0] lyr_grp [4];
        logic [8:0] px [6];
        logic [2:0] code [6];
        logic [1:0] grp [6];
        logic [1:0] sel;
        logic [8:0] res_px;
        logic [2:0] res_code;
        logic [1:0] res_grp;
        logic       scroll;
        logic       blocked;
        for (int i = 0; i < 5; i++) begin
            on[i] = (c.mask[i][5:0] & c.layer_ctrl[5:0]) != 6'h0;
        end
        lyr_px[0] = l.obj;
        lyr_px[1] = l.scr1[8:0];
        lyr_px[2] = l.scr2[8:0];
        lyr_px[3] = l.scr3[8:0];
        lyr_grp = '{2'b00, l.scr1[10:9], l.scr2[10:9], l.scr3[10:9]};
        // Index 0 is the object, scroll n sits at index n
        for (int i = 0; i < 4; i++) begin
            if (!(i == 0 ? c.gfx_en[3] : on[i-1] && c.gfx_en[i-1])) begin
                lyr_px[i][3:0] = 4'hF;
            end
        end
        px[0] = on[4] ? l.star1 : {l.star1[8:4], 4'hF};
        px[1] = on[3] ? l.star0 : {l.star0[8:4], 4'hF};
        code[0] = cps_mix_pkg::LYR_STAR;
        code[1] = cps_mix_pkg::LYR_STAR;
        grp[0] = 2'b00;
        grp[1] = 2'b00;
        for (int i = 0; i < 4; i++) begin
            sel = c.layer_ctrl[6 + 2*i +: 2];
            px[2+i] = lyr_px[sel];
            code[2+i] = {1'b0, sel};
            grp[2+i] = lyr_grp[sel];
        end
        res_px = px[0];
        res_code = code[0];
        res_grp = grp[0];
        scroll = 1'b0;
        for (int i = 1; i < 6; i++) begin
            blocked = code[i] == cps_mix_pkg::LYR_OBJ && scroll && c.prio[res_grp][res_px[3:0]];
            if (res_px[3:0] == 4'hF || (px[i][3:0] != 4'hF && !blocked)) begin
                res_px = px[i];
                res_code = code[i];
                res_grp = grp[i];
                scroll = code[i] != cps_mix_pkg::LYR_STAR;
            end else begin
                scroll = 1'b0;
            end
        end
        return {res_code, res_px};
    endfunction

    // Register map model with per-field truncation
    function automatic cps_mix_pkg::mix_cfg_t cfg_write(
        input cps_mix_pkg::mix_cfg_t c,
        input logic [7:0]            a,
        input logic [31:0]           d
    );
        if (a == 8'h00) begin
            c.layer_ctrl = d[15:0];
        end else if (a >= 8'h04 && a <= 8'h14) begin
            c.mask[3'((a - 8'h04) >> 2)] = d[7:0];
        end else if (a >= 8'h18 && a <= 8'h24) begin
            c.prio[2'((a - 8'h18) >> 2)] = d[15:0];
        end else if (a == 8'h28) begin
            c.gfx_en = d[3:0];
        end
        return c;
    endfunction

    function automatic logic [31:0] reg_bits(input logic [7:0] a);
        if (a >= 8'h04 && a <= 8'h14) begin
            return 32'hFF;
        end
        return (a == 8'h28) ? 32'hF : 32'hFFFF;
    endfunction

    // Setup phase, then access phase until pready
    task automatic apb_xfer(input logic wr, input logic [7:0] a, input logic [31:0] wd,
                            output logic [31:0] rd, output logic err);
        int n;
        @(posedge clk);
        #1;
        psel = 1'b1;
        pwrite = wr;
        paddr = a;
        pwdata = wd;
        @(posedge clk);
        #1;
        penable = 1'b1;
        n = 0;
        @(posedge clk);
        while (!pready && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!pready) begin
            timeout_fail("APB pready");
        end
        rd = prdata;
        err = pslverr;
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] a, input logic [31:0] d, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, a, d, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
        apb_xfer(1'b0, a, 32'h0, d, err);
    endtask

    task automatic set_cfg(input logic [7:0] a, input logic [31:0] d);
        logic err;
        apb_write(a, d, err);
        check_eq(32'(err), 32'h0, "pslverr on a mapped write");
        model_cfg = cfg_write(model_cfg, a, d);
    endtask

    task automatic std_cfg(input logic [15:0] ctrl);
        set_cfg(cps_mix_pkg::REG_LAYER_CTRL, {16'h0, ctrl});
        for (int i = 0; i < 5; i++) begin
            set_cfg(8'(cps_mix_pkg::REG_MASK0 + 4 * i), 32'h3F);
        end
        for (int i = 0; i < 4; i++) begin
            set_cfg(8'(cps_mix_pkg::REG_PRIO0 + 4 * i), 32'h0);
        end
        set_cfg(cps_mix_pkg::REG_GFX_EN, 32'hF);
    endtask

    task automatic wait_cen();
        int n;
        n = 0;
        @(posedge clk);
        while (!pxl_cen && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!pxl_cen) begin
            timeout_fail("pixel enable");
        end
    endtask

    // transp_mod 0 keeps all colours opaque, else 1 in transp_mod goes to 0xF
    task automatic rand_layers(input int transp_mod, output cps_mix_pkg::layer_pxls_t l);
        logic [63:0] r;
        logic [3:0]  col [6];
        r = {$random(seed), $random(seed)};
        l = r[59:0];
        for (int i = 0; i < 6; i++) begin
            col[i] = 4'($random(seed));
            if (transp_mod == 0 && col[i] == 4'hF) begin
                col[i] = 4'h7;
            end else if (transp_mod != 0 && {$random(seed)} % transp_mod == 0) begin
                col[i] = 4'hF;
            end
        end
        l.scr1[3:0] = col[0];
        l.scr2[3:0] = col[1];
        l.scr3[3:0] = col[2];
        l.star0[3:0] = col[3];
        l.star1[3:0] = col[4];
        l.obj[3:0] = col[5];
    endtask

    task automatic send_pixel(input cps_mix_pkg::layer_pxls_t l);
        wait_cen();
        #1;
        layers = l;
        exp_pxl = ref_mix(model_cfg, l);
        exp_valid = 1'b1;
    endtask

    // Drain the pipeline so every sent pixel is checked
    task automatic flush();
        wait_cen();
        #1 exp_valid = 1'b0;
        repeat (3) wait_cen();
        // Let the compare at this edge finish first
        #1;
    endtask

    task automatic run_batch(input int n, input int transp_mod);
        cps_mix_pkg::layer_pxls_t l;
        for (int i = 0; i < n; i++) begin
            rand_layers(transp_mod, l);
            send_pixel(l);
        end
        flush();
    endtask

    task automatic report_test(input string name, input int chk_base, input int err_base);
        $display("Test %s: %0d checks, %0d errors", name, chk_cnt - chk_base,
                 err_cnt - err_base);
    endtask

    // pxl read here was set at the previous enable
    always @(posedge clk) begin
        if (pxl_cen) begin
            if (v_pipe[2]) begin
                check_eq(32'(pxl), 32'(e_pipe[2]), "mixed pixel");
            end
            v_pipe = {v_pipe[1:0], exp_valid};
            e_pipe[2] = e_pipe[1];
            e_pipe[1] = e_pipe[0];
            e_pipe[0] = exp_pxl;
        end
    end

    initial begin
        cps_mix_pkg::layer_pxls_t l;
        logic [31:0] wd;
        logic [31:0] rd;
        logic        err;
        int          cb;
        int          eb;
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'h0;
        layers = '0;
        exp_valid = 1'b0;
        exp_pxl = '0;
        model_cfg = '{layer_ctrl: 16'h003F, mask: {5{8'h3F}}, prio: '0, gfx_en: 4'hF};
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        check_eq(32'(pxl), 32'h0, "pxl after reset");

        cb = chk_cnt;
        eb = err_cnt;
        for (int a = 0; a <= 40; a += 4) begin
            wd = $random(seed);
            set_cfg(8'(a), wd);
            apb_read(8'(a), rd, err);
            check_eq(rd, wd & reg_bits(8'(a)), "register readback");
        end
        apb_write(8'h2C, 32'hFFFF_FFFF, err);
        check_eq(32'(err), 32'h1, "pslverr on unmapped write");
        apb_read(8'h2C, rd, err);
        check_eq(32'(err), 32'h1, "pslverr on unmapped read");
        check_eq(rd, 32'h0, "unmapped read data");
        report_test("register readback", cb, eb);

        // Every order with all layers opaque, last slot wins
        cb = chk_cnt;
        eb = err_cnt;
        std_cfg(16'h003F);
        for (int o = 0; o < 256; o++) begin
            set_cfg(cps_mix_pkg::REG_LAYER_CTRL, {18'h0, 8'(o), 6'h3F});
            rand_layers(0, l);
            send_pixel(l);
            flush();
            // Same layers still held, so pxl shows this order
            check_eq(32'(pxl[11:9]), 32'(o >> 6), "layer code of the last slot");
        end
        report_test("layer ordering", cb, eb);

        cb = chk_cnt;
        eb = err_cnt;
        for (int k = 0; k < 6; k++) begin
            std_cfg({2'b00, 8'($random(seed)), 6'h3F});
            run_batch(10, 2);
        end
        report_test("transparency fall-through", cb, eb);

        // One mask cleared per round, random gfx enables
        cb = chk_cnt;
        eb = err_cnt;
        for (int k = 0; k < 10; k++) begin
            std_cfg({2'b00, 8'($random(seed)), 6'($random(seed))});
            set_cfg(8'(cps_mix_pkg::REG_MASK0 + 4 * (k % 5)), 32'h0);
            set_cfg(cps_mix_pkg::REG_GFX_EN, 32'($random(seed)));
            run_batch(10, 3);
        end
        report_test("enables and gfx_en", cb, eb);

        // Scroll 1, 2, 3 then object, prio all set, clear, random
        cb = chk_cnt;
        eb = err_cnt;
        for (int k = 0; k < 3; k++) begin
            std_cfg(16'h0E7F);
            for (int g = 0; g < 4; g++) begin
                wd = (k == 0) ? 32'hFFFF : (k == 1) ? 32'h0 : $random(seed);
                set_cfg(8'(cps_mix_pkg::REG_PRIO0 + 4 * g), wd);
            end
            run_batch(20, 4);
        end
        report_test("object priority", cb, eb);

        cb = chk_cnt;
        eb = err_cnt;
        for (int f = 0; f < 15; f++) begin
            for (int a = 0; a <= 40; a += 4) begin
                set_cfg(8'(a), $random(seed));
            end
            run_batch(20, 3);
        end
        report_test("random soak", cb, eb);

        $display("Done: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- cps_mix.f
src/cps_mix_pkg.sv
src/cps_mix_regs.sv
src/cps_layer_gate.sv
src/cps_layer_mixer.sv
src/cps_video_mixer.sv
verification/cps_mix_chk.sv
verification/tb_cps_video_mixer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the colour mixer testbench with Verilator and runs it into sim.log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f cps_mix.f \
    --top-module tb_cps_video_mixer \
    -o sim_cps_mix

./obj_dir/sim_cps_mix 2>&1 | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
